// ==== Bender.yml ====
package:
  name: cache_arbiter

sources:
  # Packages first, then the design in dependency order
  - hw/lc3b_types.sv
  - hw/arbiter_pkg.sv
  - hw/arbiter_control.sv
  - hw/arbiter_datapath.sv
  - hw/l2_memory.sv
  - hw/cache_arbiter.sv

  # Testbench, top module cache_arbiter_tb
  - target: test
    files:
      - verification/cache_arbiter_tb.sv

// ==== files.f ====
hw/lc3b_types.sv
hw/arbiter_pkg.sv
hw/arbiter_control.sv
hw/arbiter_datapath.sv
hw/l2_memory.sv
hw/cache_arbiter.sv
verification/cache_arbiter_tb.sv

// ==== hw/arbiter_control.sv ====
// Cache arbiter FSM
// Picks the served L1, delays the L2 strobes, alternates on contention
`timescale 1ns/1ns

module arbiter_control
	import lc3b_types::*;
	import arbiter_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_arst_n,

	// Request summary from the datapath
	input  logic     i_icache_pending,
	input  logic     i_dcache_pending,

	// Access done
	input  logic     i_l2_resp,

	output arb_sel_e o_sel,
	output logic     o_l2_enable
);

	arb_state_e state_q;

	// Current owner, kept after the access so it
	// also serves as the last-served bit
	arb_sel_e sel_q;

	// Requester picked if a grant is made this cycle
	arb_sel_e pick;

	always_comb
	begin
		// Both waiting: give it to the one not served last
		if (i_icache_pending && i_dcache_pending)
		begin
			pick = (sel_q == SEL_ICACHE) ? SEL_DCACHE : SEL_ICACHE;
		end
		else if (i_dcache_pending)
		begin
			pick = SEL_DCACHE;
		end
		else
		begin
			pick = SEL_ICACHE;
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			state_q <= IDLE;
			// D-cache counts as last served, so I-cache wins first
			sel_q   <= SEL_DCACHE;
		end
		else
		begin
			case (state_q)
				IDLE:
				begin
					// Selection is latched on entry and held for the access
					if (i_icache_pending || i_dcache_pending)
					begin
						state_q <= GRANT;
						sel_q   <= pick;
					end
				end
				GRANT:
				begin
					if (i_l2_resp)
					begin
						state_q <= RELEASE;
					end
				end
				RELEASE:
				begin
					state_q <= IDLE;
				end
				default:
				begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	assign o_sel       = sel_q;
	// L2 only sees strobes while granted, one cycle after the request
	assign o_l2_enable = (state_q == GRANT);

	// L2 never answers a request the arbiter did not pass on
	resp_only_in_grant: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_l2_resp |-> (state_q == GRANT))
		else $error("L2 response outside grant");

endmodule : arbiter_control

// ==== hw/arbiter_datapath.sv ====
// Cache arbiter datapath
// Steers the owning L1 onto the L2 port and routes the response back
`timescale 1ns/1ns

module arbiter_datapath
	import lc3b_types::*;
	import arbiter_pkg::*;
(
	// Split L1 requests
	input  lc3b_word      i_icache_address,
	input  lc3b_word      i_dcache_address,
	input  lc3b_cacheline i_icache_wdata,
	input  lc3b_cacheline i_dcache_wdata,
	input  logic          i_icache_read,
	input  logic          i_dcache_read,
	input  logic          i_icache_write,
	input  logic          i_dcache_write,

	// From the arbiter FSM
	input  arb_sel_e      i_sel,
	input  logic          i_l2_enable,

	// From the L2
	input  lc3b_cacheline i_l2_rdata,
	input  logic          i_l2_resp,

	// To the L2
	output lc3b_word      o_l2_address,
	output lc3b_cacheline o_l2_wdata,
	output logic          o_l2_read,
	output logic          o_l2_write,

	// Back to the split L1
	output logic          o_icache_resp,
	output logic          o_dcache_resp,
	output lc3b_cacheline o_icache_rdata,
	output lc3b_cacheline o_dcache_rdata,

	// Request summary for the FSM
	output logic          o_icache_pending,
	output logic          o_dcache_pending
);

	logic dsel;

	assign dsel = (i_sel == SEL_DCACHE);

	always_comb
	begin
		// Address and line data follow the owner
		o_l2_address = dsel ? i_dcache_address : i_icache_address;
		o_l2_wdata   = dsel ? i_dcache_wdata : i_icache_wdata;

		// Strobes held back until the FSM grants the port
		o_l2_read  = (dsel ? i_dcache_read : i_icache_read) & i_l2_enable;
		o_l2_write = (dsel ? i_dcache_write : i_icache_write) & i_l2_enable;

		// Response only to the owner, data to both
		o_dcache_resp  = dsel & i_l2_resp;
		o_icache_resp  = ~dsel & i_l2_resp;
		o_dcache_rdata = i_l2_rdata;
		o_icache_rdata = i_l2_rdata;

		o_icache_pending = i_icache_read | i_icache_write;
		o_dcache_pending = i_dcache_read | i_dcache_write;
	end

	// A response reaches only a cache still holding its request
	resp_to_waiting: assert final ((!o_icache_resp || o_icache_pending) &&
		(!o_dcache_resp || o_dcache_pending))
		else $error("response sent to a cache with no request");

endmodule : arbiter_datapath

// ==== hw/arbiter_pkg.sv ====
// Arbiter state encoding and requester select encoding
package arbiter_pkg;

	// Controller states
	// IDLE waits for a request, GRANT owns the L2,
	// RELEASE gives the served L1 a cycle to drop its strobe
	typedef enum logic [1:0]
	{
		IDLE    = 2'b00,
		GRANT   = 2'b01,
		RELEASE = 2'b10
	} arb_state_e;

	// Which L1 owns the L2 port
	// Same meaning on the control and datapath side
	typedef enum logic
	{
		SEL_ICACHE = 1'b0,
		SEL_DCACHE = 1'b1
	} arb_sel_e;

endpackage : arbiter_pkg

// ==== hw/cache_arbiter.sv ====
// Cache arbiter top level
// Arbiter FSM, datapath and behavioral L2 store
`timescale 1ns/1ns

module cache_arbiter
	import lc3b_types::*;
	import arbiter_pkg::*;
#(
	parameter int L2_LATENCY    = 3,
	parameter int L2_INDEX_BITS = 6
)
(
	input  logic          i_clk,
	input  logic          i_arst_n,

	// Instruction cache side
	input  lc3b_word      i_icache_address,
	input  lc3b_cacheline i_icache_wdata,
	input  logic          i_icache_read,
	input  logic          i_icache_write,
	output logic          o_icache_resp,
	output lc3b_cacheline o_icache_rdata,

	// Data cache side
	input  lc3b_word      i_dcache_address,
	input  lc3b_cacheline i_dcache_wdata,
	input  logic          i_dcache_read,
	input  logic          i_dcache_write,
	output logic          o_dcache_resp,
	output lc3b_cacheline o_dcache_rdata
);

	// FSM to datapath
	arb_sel_e      sel;
	logic          l2_enable;
	logic          icache_pending;
	logic          dcache_pending;

	// Datapath to L2 and back
	lc3b_word      l2_address;
	lc3b_cacheline l2_wdata;
	logic          l2_read;
	logic          l2_write;
	lc3b_cacheline l2_rdata;
	logic          l2_resp;

	arbiter_control arbiter_control_inst
	(
		.i_clk            (i_clk),
		.i_arst_n         (i_arst_n),
		.i_icache_pending (icache_pending),
		.i_dcache_pending (dcache_pending),
		.i_l2_resp        (l2_resp),
		.o_sel            (sel),
		.o_l2_enable      (l2_enable)
	);

	arbiter_datapath arbiter_datapath_inst
	(
		.i_icache_address (i_icache_address),
		.i_dcache_address (i_dcache_address),
		.i_icache_wdata   (i_icache_wdata),
		.i_dcache_wdata   (i_dcache_wdata),
		.i_icache_read    (i_icache_read),
		.i_dcache_read    (i_dcache_read),
		.i_icache_write   (i_icache_write),
		.i_dcache_write   (i_dcache_write),
		.i_sel            (sel),
		.i_l2_enable      (l2_enable),
		.i_l2_rdata       (l2_rdata),
		.i_l2_resp        (l2_resp),
		.o_l2_address     (l2_address),
		.o_l2_wdata       (l2_wdata),
		.o_l2_read        (l2_read),
		.o_l2_write       (l2_write),
		.o_icache_resp    (o_icache_resp),
		.o_dcache_resp    (o_dcache_resp),
		.o_icache_rdata   (o_icache_rdata),
		.o_dcache_rdata   (o_dcache_rdata),
		.o_icache_pending (icache_pending),
		.o_dcache_pending (dcache_pending)
	);

	// Shared L2 behind the arbiter
	l2_memory #(
		.L2_LATENCY    (L2_LATENCY),
		.L2_INDEX_BITS (L2_INDEX_BITS)
	) l2_memory_inst
	(
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_address (l2_address),
		.i_wdata   (l2_wdata),
		.i_read    (l2_read),
		.i_write   (l2_write),
		.o_rdata   (l2_rdata),
		.o_resp    (l2_resp)
	);

endmodule : cache_arbiter

// ==== hw/l2_memory.sv ====
// Behavioral L2 line store
// Fixed access latency, one-cycle response pulse
`timescale 1ns/1ns

module l2_memory
	import lc3b_types::*;
#(
	parameter int L2_LATENCY    = 3,
	parameter int L2_INDEX_BITS = 6
)
(
	input  logic          i_clk,
	input  logic          i_arst_n,

	input  lc3b_word      i_address,
	input  lc3b_cacheline i_wdata,
	input  logic          i_read,
	input  logic          i_write,

	output lc3b_cacheline o_rdata,
	output logic          o_resp
);

	localparam int LINES = 2 ** L2_INDEX_BITS;
	localparam int CNT_W = $clog2(L2_LATENCY + 1);

	// Counter value on the edge that completes the access
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(L2_LATENCY - 1);

	lc3b_cacheline mem [LINES];

	logic [L2_INDEX_BITS-1:0] index;
	logic [CNT_W-1:0]         cnt_q;
	logic                     busy_q;
	logic                     strobe;
	logic                     start;
	logic                     finish;

	// Line index sits right above the byte offset
	assign index  = i_address[LINE_OFFSET_BITS +: L2_INDEX_BITS];
	assign strobe = i_read | i_write;

	// First strobe cycle already counts as one latency cycle
	assign start  = strobe & ~busy_q;
	assign finish = (L2_LATENCY == 1) ? start : (busy_q & ~o_resp & (cnt_q == CNT_LAST));

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			busy_q <= 1'b0;
			cnt_q  <= '0;
			o_resp <= 1'b0;
		end
		else
		begin
			o_resp <= finish;
			// Stay busy through the response cycle so the held strobe is ignored
			if (o_resp)
			begin
				busy_q <= 1'b0;
			end
			else if (start)
			begin
				busy_q <= 1'b1;
				cnt_q  <= CNT_W'(1);
			end
			else if (busy_q)
			begin
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	// Line array, written and read when the access completes
	always_ff @(posedge i_clk)
	begin
		if (finish)
		begin
			if (i_write)
			begin
				mem[index] <= i_wdata;
			end
			o_rdata <= mem[index];
		end
	end

	// Clean contents at time zero for the model
	initial
	begin
		for (int i = 0; i < LINES; i++)
		begin
			mem[i] = '0;
		end
	end

	rw_exclusive: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		!(i_read && i_write))
		else $error("L2 read and write high together");

	// Requester holds its strobe for the whole access
	strobe_held: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		(busy_q && !o_resp) |-> strobe)
		else $error("L2 strobe dropped before response");

endmodule : l2_memory

// ==== hw/lc3b_types.sv ====
// Processor word and cache line types
// Line geometry shared by the L1 caches and the L2 store
package lc3b_types;

	// Machine word, also the byte address width
	localparam int WORD_BITS = 16;

	// A line holds eight words
	localparam int LINE_WORDS = 8;
	localparam int LINE_BITS = WORD_BITS * LINE_WORDS;

	// Byte offset inside a line, dropped when indexing the L2
	localparam int LINE_OFFSET_BITS = $clog2(LINE_BITS / 8);

	// 16-bit byte address
	typedef logic [WORD_BITS-1:0] lc3b_word;

	// Full 128-bit line, the unit of every L1/L2 transfer
	typedef logic [LINE_BITS-1:0] lc3b_cacheline;

endpackage : lc3b_types

// ==== verification/cache_arbiter_tb.sv ====
// Cache arbiter testbench
// Two L1 request drivers, shadow L2 contents and checking assertions
`timescale 1ns/1ns

module cache_arbiter_tb
	import lc3b_types::*;
();

	localparam int L2_LATENCY = 3;
	localparam int INDEX_BITS = 6;
	localparam int TIMEOUT    = 50;

	logic          clk;
	logic          arst_n;
	lc3b_word      icache_address;
	lc3b_cacheline icache_wdata;
	logic          icache_read;
	logic          icache_write;
	logic          o_icache_resp;
	lc3b_cacheline o_icache_rdata;
	lc3b_word      dcache_address;
	lc3b_cacheline dcache_wdata;
	logic          dcache_read;
	logic          dcache_write;
	logic          o_dcache_resp;
	lc3b_cacheline o_dcache_rdata;

	int            check_errors;
	int            timeout_errors;
	string         test_name;
	logic [15:0]   lfsr;

	// Expected L2 contents, zero like the store after power-up
	lc3b_cacheline shadow [2**INDEX_BITS];
	logic [INDEX_BITS-1:0] i_idx;
	logic [INDEX_BITS-1:0] d_idx;
	lc3b_cacheline i_expected;
	lc3b_cacheline d_expected;

	logic          i_req;
	logic          d_req;
	logic          l2_rd;
	logic          l2_wr;
	lc3b_word      l2_addr;
	// Set while the data cache was served last
	logic          last_served_d;
	logic [2:0]    post_rst_cycles;

	cache_arbiter cache_arbiter_inst
	(
		.i_clk            (clk),
		.i_arst_n         (arst_n),
		.i_icache_address (icache_address),
		.i_icache_wdata   (icache_wdata),
		.i_icache_read    (icache_read),
		.i_icache_write   (icache_write),
		.o_icache_resp    (o_icache_resp),
		.o_icache_rdata   (o_icache_rdata),
		.i_dcache_address (dcache_address),
		.i_dcache_wdata   (dcache_wdata),
		.i_dcache_read    (dcache_read),
		.i_dcache_write   (dcache_write),
		.o_dcache_resp    (o_dcache_resp),
		.o_dcache_rdata   (o_dcache_rdata)
	);

	always #5 clk = ~clk;

	assign i_req      = icache_read | icache_write;
	assign d_req      = dcache_read | dcache_write;
	assign i_idx      = icache_address[LINE_OFFSET_BITS +: INDEX_BITS];
	assign d_idx      = dcache_address[LINE_OFFSET_BITS +: INDEX_BITS];
	assign i_expected = shadow[i_idx];
	assign d_expected = shadow[d_idx];

	// L2 port seen from inside the top level
	assign l2_rd   = cache_arbiter_inst.l2_read;
	assign l2_wr   = cache_arbiter_inst.l2_write;
	assign l2_addr = cache_arbiter_inst.l2_address;

	// A write lands in the L2 on its response
	always @(posedge clk)
	begin
		if (o_icache_resp && icache_write)
		begin
			shadow[i_idx] <= icache_wdata;
		end
		if (o_dcache_resp && dcache_write)
		begin
			shadow[d_idx] <= dcache_wdata;
		end
	end

	// D-cache counts as last served out of reset
	always @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			last_served_d   <= 1'b1;
			post_rst_cycles <= '0;
		end
		else
		begin
			if (o_icache_resp)
			begin
				last_served_d <= 1'b0;
			end
			else if (o_dcache_resp)
			begin
				last_served_d <= 1'b1;
			end
			if (post_rst_cycles != 3'd7)
			begin
				post_rst_cycles <= post_rst_cycles + 1'b1;
			end
		end
	end

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic lfsr_step();
		logic fb;
		fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [127:0] rand_bits(input int n);
		logic [127:0] v;
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			v = {v[126:0], lfsr_step()};
		end
		return v;
	endfunction

	// One L1 line access, called and returning just after a clock edge
	task automatic l1_access(input bit dcache, input bit is_write, input lc3b_word addr,
		input lc3b_cacheline line);
		int waited;
		bit got;
		if (dcache)
		begin
			dcache_address <= addr;
			dcache_wdata   <= line;
			dcache_read    <= !is_write;
			dcache_write   <= is_write;
		end
		else
		begin
			icache_address <= addr;
			icache_wdata   <= line;
			icache_read    <= !is_write;
			icache_write   <= is_write;
		end
		got    = 1'b0;
		waited = 0;
		while (!got && waited < TIMEOUT)
		begin
			@(posedge clk);
			waited++;
			got = dcache ? o_dcache_resp : o_icache_resp;
		end
		if (dcache)
		begin
			dcache_read  <= 1'b0;
			dcache_write <= 1'b0;
		end
		else
		begin
			icache_read  <= 1'b0;
			icache_write <= 1'b0;
		end
		if (!got)
		begin
			timeout_errors++;
			$display("%s cache request to %h never got its response",
				dcache ? "data" : "instruction", addr);
		end
		// Strobe stays low two cycles, next request starts from idle
		repeat (2) @(posedge clk);
	endtask

	initial
	begin
		int choice;
		bit wr_i;
		bit wr_d;
		lc3b_word a_i;
		lc3b_word a_d;
		lc3b_cacheline l_i;
		lc3b_cacheline l_d;
		lfsr           = 16'd82;
		clk            = 1'b0;
		arst_n         = 1'b0;
		icache_address = '0;
		icache_wdata   = '0;
		icache_read    = 1'b0;
		icache_write   = 1'b0;
		dcache_address = '0;
		dcache_wdata   = '0;
		dcache_read    = 1'b0;
		dcache_write   = 1'b0;
		check_errors   = 0;
		timeout_errors = 0;
		for (int k = 0; k < 2**INDEX_BITS; k++)
		begin
			shadow[k] = '0;
		end
		test_name = "reset_quiet";
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
		repeat (4) @(posedge clk);

		test_name = "d_write_read";
		a_d = lc3b_word'(rand_bits(LINE_OFFSET_BITS + INDEX_BITS));
		l_d = rand_bits(128);
		l1_access(1'b1, 1'b1, a_d, l_d);
		l1_access(1'b1, 1'b0, a_d, '0);
		test_name = "shared_l2";
		l1_access(1'b0, 1'b0, a_d, '0);

		test_name = "fixed_latency";
		for (int n = 0; n < 4; n++)
		begin
			a_i = lc3b_word'(rand_bits(LINE_OFFSET_BITS + INDEX_BITS));
			l1_access(n[0], 1'b0, a_i, '0);
		end

		// Both strobes rise on the same edge
		test_name = "contention";
		for (int n = 0; n < 4; n++)
		begin
			wr_i = rand_bits(1);
			wr_d = rand_bits(1);
			a_i  = lc3b_word'(rand_bits(LINE_OFFSET_BITS + INDEX_BITS));
			a_d  = lc3b_word'(rand_bits(LINE_OFFSET_BITS + INDEX_BITS));
			l_i  = rand_bits(128);
			l_d  = rand_bits(128);
			fork
				l1_access(1'b0, wr_i, a_i, l_i);
				l1_access(1'b1, wr_d, a_d, l_d);
			join
		end

		// Values drawn before any fork so the sequence stays fixed
		test_name = "random_mix";
		for (int n = 0; n < 40; n++)
		begin
			choice = int'(rand_bits(2));
			wr_i   = rand_bits(1);
			wr_d   = rand_bits(1);
			a_i    = lc3b_word'(rand_bits(LINE_OFFSET_BITS + INDEX_BITS));
			a_d    = lc3b_word'(rand_bits(LINE_OFFSET_BITS + INDEX_BITS));
			l_i    = rand_bits(128);
			l_d    = rand_bits(128);
			case (choice)
				0: l1_access(1'b0, wr_i, a_i, l_i);
				1: l1_access(1'b1, wr_d, a_d, l_d);
				default:
				begin
					fork
						l1_access(1'b0, wr_i, a_i, l_i);
						l1_access(1'b1, wr_d, a_d, l_d);
					join
				end
			endcase
		end

		repeat (4) @(posedge clk);
		$display("check errors %0d, timeouts %0d", check_errors, timeout_errors);
		if (check_errors == 0 && timeout_errors == 0)
		begin
			$display("TESTS PASSED");
		end
		else
		begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// Nothing moves during reset and the first cycles after it
	reset_quiet: assert property (@(posedge clk)
		(!arst_n || post_rst_cycles < 3'd3) |->
		!(o_icache_resp || o_dcache_resp || l2_rd || l2_wr))
		else
		begin
			check_errors++;
			$display("ERR %s expected 0000 actual %b%b%b%b", test_name, $sampled(o_icache_resp),
				$sampled(o_dcache_resp), $sampled(l2_rd), $sampled(l2_wr));
		end

	// L2 port carries a waiting requester's address and strobe
	l2_addr_owner: assert property (@(posedge clk) disable iff (!arst_n)
		(l2_rd || l2_wr) |->
		((i_req && l2_addr == icache_address && l2_rd == icache_read) ||
		(d_req && l2_addr == dcache_address && l2_rd == dcache_read)))
		else
		begin
			check_errors++;
			$display("ERR %s expected address %h or %h actual %h", test_name,
				$sampled(icache_address), $sampled(dcache_address), $sampled(l2_addr));
		end

	read_data_i: assert property (@(posedge clk) disable iff (!arst_n)
		(o_icache_resp && icache_read) |-> o_icache_rdata == i_expected)
		else
		begin
			check_errors++;
			$display("ERR %s expected %h actual %h", test_name,
				$sampled(i_expected), $sampled(o_icache_rdata));
		end

	read_data_d: assert property (@(posedge clk) disable iff (!arst_n)
		(o_dcache_resp && dcache_read) |-> o_dcache_rdata == d_expected)
		else
		begin
			check_errors++;
			$display("ERR %s expected %h actual %h", test_name,
				$sampled(d_expected), $sampled(o_dcache_rdata));
		end

	// Lone request into an idle arbiter
	fixed_latency_i: assert property (@(posedge clk) disable iff (!arst_n)
		($rose(i_req) && !$past(i_req, 2) && !d_req && !$past(d_req) && !$past(d_req, 2))
		|-> !o_icache_resp [*(L2_LATENCY + 1)] ##1 o_icache_resp)
		else
		begin
			check_errors++;
			$display("ERR %s expected icache resp after %0d cycles actual resp %b",
				test_name, L2_LATENCY + 1, $sampled(o_icache_resp));
		end

	fixed_latency_d: assert property (@(posedge clk) disable iff (!arst_n)
		($rose(d_req) && !$past(d_req, 2) && !i_req && !$past(i_req) && !$past(i_req, 2))
		|-> !o_dcache_resp [*(L2_LATENCY + 1)] ##1 o_dcache_resp)
		else
		begin
			check_errors++;
			$display("ERR %s expected dcache resp after %0d cycles actual resp %b",
				test_name, L2_LATENCY + 1, $sampled(o_dcache_resp));
		end

	// Loser is granted in the idle cycle after release
	contention_i_first: assert property (@(posedge clk) disable iff (!arst_n)
		($rose(i_req) && $rose(d_req) && !$past(i_req, 2) && !$past(d_req, 2) && last_served_d)
		|-> !(o_icache_resp || o_dcache_resp) [*(L2_LATENCY + 1)]
		##1 (o_icache_resp && !o_dcache_resp)
		##1 !(o_icache_resp || o_dcache_resp) [*(L2_LATENCY + 2)]
		##1 (o_dcache_resp && !o_icache_resp))
		else
		begin
			check_errors++;
			$display("ERR %s expected order icache then dcache actual resp %b%b",
				test_name, $sampled(o_icache_resp), $sampled(o_dcache_resp));
		end

	contention_d_first: assert property (@(posedge clk) disable iff (!arst_n)
		($rose(i_req) && $rose(d_req) && !$past(i_req, 2) && !$past(d_req, 2) && !last_served_d)
		|-> !(o_icache_resp || o_dcache_resp) [*(L2_LATENCY + 1)]
		##1 (o_dcache_resp && !o_icache_resp)
		##1 !(o_icache_resp || o_dcache_resp) [*(L2_LATENCY + 2)]
		##1 (o_icache_resp && !o_dcache_resp))
		else
		begin
			check_errors++;
			$display("ERR %s expected order dcache then icache actual resp %b%b",
				test_name, $sampled(o_icache_resp), $sampled(o_dcache_resp));
		end

	// Each response is a single pulse to one cache
	resp_single_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		(o_icache_resp || o_dcache_resp) |->
		!(o_icache_resp && o_dcache_resp) ##1 !(o_icache_resp || o_dcache_resp))
		else
		begin
			check_errors++;
			$display("ERR %s expected single response pulse actual resp %b%b",
				test_name, $sampled(o_icache_resp), $sampled(o_dcache_resp));
		end

endmodule : cache_arbiter_tb
